// ==== Makefile ====
# Verilator build and run of the complex multiplier testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_top with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_top -f build.f
	./obj_dir/Vtb_top > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
common/cm_pkg.sv
logic/cm_regfile.sv
logic/cm_ctrl_fsm.sv
logic/cm_seq_counters.sv
logic/cm_mem_port.sv
cmult/cm_mult_core.sv
logic/cm_top.sv
tests/tb_clk_gen.sv
tests/tb_mem_model.sv
tests/tb_top.sv

// ==== cmult/cm_mult_core.sv ====
// cm_mult_core: two-stage pipelined signed complex multiplier with valid/ready handshake
`timescale 1ns/100ps
`default_nettype none

module cm_mult_core (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         op_val,
    output logic                        op_rdy,
    input  wire  cm_pkg::byte_t [3:0]   op_data,    // {x1, y1, x2, y2}
    output logic                        res_val,
    input  wire                         res_rdy,
    output cm_pkg::res_t                xr,         // x1*x2 - y1*y2
    output cm_pkg::res_t                yr          // x1*y2 + y1*x2
);
    import cm_pkg::*;

    logic                        adv;               // whole pipeline moves
    logic                        s1_val;            // products valid
    logic signed [2*DWIDTH-1:0]  p_x1x2, p_y1y2, p_x1y2, p_y1x2;
    logic signed [RES_W-1:0]     xr_q, yr_q;

    assign adv    = ~(res_val & ~res_rdy);          // freeze while the result waits
    assign op_rdy = adv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_val  <= 1'b0;
            res_val <= 1'b0;
        end else if (adv) begin
            s1_val  <= op_val;
            res_val <= s1_val;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            // stage 1
            p_x1x2 <= $signed(op_data[3]) * $signed(op_data[1]);
            p_y1y2 <= $signed(op_data[2]) * $signed(op_data[0]);
            p_x1y2 <= $signed(op_data[3]) * $signed(op_data[0]);
            p_y1x2 <= $signed(op_data[2]) * $signed(op_data[1]);
            // stage 2 sums are sign-extended to RES_W
            xr_q   <= p_x1x2 - p_y1y2;
            yr_q   <= p_x1y2 + p_y1x2;
        end
    end

    assign xr = xr_q;
    assign yr = yr_q;

endmodule

`default_nettype wire

// ==== common/cm_pkg.sv ====
// shared widths, typedefs, register offsets, byte counts and the control state enum
`default_nettype none

package cm_pkg;

    localparam int SYS_AW = 32;              // system and memory address width
    localparam int REG_DW = 32;              // register data width
    localparam int DWIDTH = 8;               // operand element width, set by the byte-wide memory
    localparam int RES_W  = 2*DWIDTH + 2;    // width of xr or yr

    typedef logic [SYS_AW-1:0] addr_t;       // memory address
    typedef logic [REG_DW-1:0] reg_t;        // register word
    typedef logic [DWIDTH-1:0] byte_t;       // memory byte or operand element
    typedef logic [RES_W-1:0]  res_t;        // one result component
    typedef logic [REG_DW-1:0] opcnt_t;      // operation index or count
    typedef logic [2:0]        bcnt_t;       // byte index inside a phase

    localparam int OP_BYTES   = 4;           // x1 y1 x2 y2
    localparam int RES_BYTES  = 6;           // yr then xr, three bytes each
    localparam int OP_STRIDE  = 2;           // operand pointer step per operation
    localparam int RES_STRIDE = 6;           // result pointer step per operation

    // register offsets from the register file base
    localparam addr_t OFF_OP1   = addr_t'(0);
    localparam addr_t OFF_OP2   = addr_t'(1);
    localparam addr_t OFF_RES   = addr_t'(2);
    localparam addr_t OFF_NOP   = addr_t'(3);
    localparam addr_t OFF_START = addr_t'(4);
    localparam addr_t OFF_STS   = addr_t'(5);

    typedef enum logic [1:0] {
        IDLE,                                // waiting for start
        RD_OPS,                              // fetching four operand bytes
        WORK,                                // multiplier busy
        WR_RES                               // storing six result bytes
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/cm_ctrl_fsm.sv ====
// cm_ctrl_fsm: control state machine for operand read, multiply and result write
`timescale 1ns/100ps
`default_nettype none

module cm_ctrl_fsm (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,         // run requested
    input  wire                  rd_done,       // last operand byte read
    input  wire                  res_val,       // multiplier result ready
    input  wire                  next_op,       // more operations left
    input  wire                  finish,        // run complete
    output cm_pkg::ctrl_state_t  state
);
    import cm_pkg::*;

    ctrl_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:
                if (start)
                    state_nxt = RD_OPS;
            RD_OPS:
                if (rd_done)
                    state_nxt = WORK;
            WORK:
                if (res_val)
                    state_nxt = WR_RES;
            default: begin                       // WR_RES
                if (finish)
                    state_nxt = IDLE;
                else if (next_op)
                    state_nxt = RD_OPS;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    a_state_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(state));

endmodule

`default_nettype wire

// ==== logic/cm_mem_port.sv ====
// memory address and strobe generation, operand gathering, result serializing
`timescale 1ns/100ps
`default_nettype none

module cm_mem_port (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  cm_pkg::ctrl_state_t   state,
    input  wire                         start,
    input  wire  cm_pkg::bcnt_t         byte_cnt,
    input  wire                         rd_done,
    input  wire                         wr_done,
    input  wire                         next_op,
    input  wire                         res_val,
    input  wire  cm_pkg::addr_t         op1_addr,
    input  wire  cm_pkg::addr_t         op2_addr,
    input  wire  cm_pkg::addr_t         res_addr,
    input  wire  cm_pkg::res_t          xr,
    input  wire  cm_pkg::res_t          yr,
    input  wire                         op_rdy,
    output logic                        op_val,
    output cm_pkg::byte_t [3:0]         op_data,    // {x1, y1, x2, y2}
    output logic                        res_rdy,
    output logic                        mem_ce,
    output logic                        mem_we,
    output cm_pkg::addr_t               mem_addr,
    output cm_pkg::byte_t               mem_wr_data,
    input  wire  cm_pkg::byte_t         mem_rd_data
);
    import cm_pkg::*;

    localparam int EXT_W = (RES_BYTES / 2) * DWIDTH;    // sign-extended component width

    logic                         set_ce, set_we, set_rdy;
    logic                         rd_pend;              // read data arrives this cycle
    byte_t                        x1_q, y1_q, x2_q;
    logic [EXT_W-1:0]             xr_ext, yr_ext;
    logic [RES_BYTES*DWIDTH-1:0]  res_bytes;

    assign set_ce  = ((state == IDLE)   & start)    |  // IDLE -> RD_OPS
                     ((state == WORK)   & res_val)  |  // WORK -> WR_RES
                     ((state == WR_RES) & next_op);    // WR_RES -> RD_OPS
    assign set_we  = (state == WORK) & res_val;
    assign set_rdy = (state == WR_RES) && (byte_cnt == bcnt_t'(RES_BYTES - 2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ce  <= 1'b0;
            mem_we  <= 1'b0;
            rd_pend <= 1'b0;
            op_val  <= 1'b0;
            res_rdy <= 1'b0;
        end else begin
            if (set_ce)
                mem_ce <= 1'b1;
            else if (rd_done || wr_done)
                mem_ce <= 1'b0;
            if (set_we)
                mem_we <= 1'b1;
            else if (wr_done)
                mem_we <= 1'b0;
            rd_pend <= mem_ce & ~mem_we;
            if (rd_done)
                op_val <= 1'b1;                         // y2 is on the bus next cycle
            else if (op_rdy)
                op_val <= 1'b0;
            if (set_rdy)
                res_rdy <= 1'b1;                        // release result on the last write
            else if (wr_done)
                res_rdy <= 1'b0;
        end
    end

    // operand pairs are little-endian x then y
    always_comb begin
        if (state == RD_OPS) begin
            if (byte_cnt < bcnt_t'(OP_BYTES / 2))
                mem_addr = op1_addr + addr_t'(byte_cnt);
            else
                mem_addr = op2_addr + addr_t'(byte_cnt) - addr_t'(OP_BYTES / 2);
        end else begin
            mem_addr = res_addr + addr_t'(byte_cnt);
        end
    end

    // byte_cnt is one ahead of the returning data
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            case (byte_cnt)
                3'd1:    x1_q <= mem_rd_data;
                3'd2:    y1_q <= mem_rd_data;
                3'd3:    x2_q <= mem_rd_data;
                default: ;
            endcase
        end
    end

    assign op_data = {x1_q, y1_q, x2_q, mem_rd_data};     // y2 taken straight off the bus

    assign yr_ext      = {{(EXT_W-RES_W){yr[RES_W-1]}}, yr};
    assign xr_ext      = {{(EXT_W-RES_W){xr[RES_W-1]}}, xr};
    assign res_bytes   = {xr_ext, yr_ext};                // yr in the low three bytes
    assign mem_wr_data = res_bytes[byte_cnt*DWIDTH +: DWIDTH];

    a_we_with_ce:  assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> mem_ce);
    a_op_val_held: assert property (@(posedge clk) disable iff (!rst_n)
        op_val && !op_rdy |=> op_val && $stable(op_data));

endmodule

`default_nettype wire

// ==== logic/cm_regfile.sv ====
// cm_regfile: config, start and status registers with the running operand and result pointers
`timescale 1ns/100ps
`default_nettype none

module cm_regfile #(
    parameter cm_pkg::addr_t RF_BADDR = '0       // register file base address
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  cm_pkg::addr_t   rf_addr,       // register write address
    input  wire                   rf_wr,         // register write strobe
    input  wire  cm_pkg::reg_t    rf_cfg,        // register write data
    output cm_pkg::reg_t          rf_sts,        // status register
    output logic                  start,         // run requested / in progress
    output cm_pkg::opcnt_t        no_op,         // operations per run
    output cm_pkg::addr_t         op1_addr,      // operand 1 pointer
    output cm_pkg::addr_t         op2_addr,      // operand 2 pointer
    output cm_pkg::addr_t         res_addr,      // result pointer
    input  wire                   rd_done,       // operand bytes fetched
    input  wire                   wr_done,       // result bytes stored
    input  wire                   finish         // last operation stored
);
    import cm_pkg::*;

    logic sel_op1, sel_op2, sel_res, sel_nop, sel_start, sel_sts;
    logic done_q;                                // status bit 0

    assign sel_op1   = rf_wr & (rf_addr == RF_BADDR + OFF_OP1);
    assign sel_op2   = rf_wr & (rf_addr == RF_BADDR + OFF_OP2);
    assign sel_res   = rf_wr & (rf_addr == RF_BADDR + OFF_RES);
    assign sel_nop   = rf_wr & (rf_addr == RF_BADDR + OFF_NOP);
    assign sel_start = rf_wr & (rf_addr == RF_BADDR + OFF_START);
    assign sel_sts   = rf_wr & (rf_addr == RF_BADDR + OFF_STS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_addr <= '0;
            op2_addr <= '0;
            res_addr <= '0;
            no_op    <= '0;
        end else begin
            if (sel_op1)
                op1_addr <= addr_t'(rf_cfg);
            else if (rd_done)
                op1_addr <= op1_addr + addr_t'(OP_STRIDE);    // next x1/y1 pair
            if (sel_op2)
                op2_addr <= addr_t'(rf_cfg);
            else if (rd_done)
                op2_addr <= op2_addr + addr_t'(OP_STRIDE);    // next x2/y2 pair
            if (sel_res)
                res_addr <= addr_t'(rf_cfg);
            else if (wr_done)
                res_addr <= res_addr + addr_t'(RES_STRIDE);   // next 6-byte slot
            if (sel_nop)
                no_op <= opcnt_t'(rf_cfg);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (finish)
                start <= 1'b0;                   // self-clearing at end of run
            else if (sel_start)
                start <= rf_cfg[0];
            if (sel_sts)
                done_q <= 1'b0;                  // software acknowledge
            else if (finish)
                done_q <= 1'b1;
        end
    end

    assign rf_sts = {{(REG_DW-1){1'b0}}, done_q};

    // the counters may only close a run that software started
    a_finish_in_run: assert property (@(posedge clk) disable iff (!rst_n) finish |-> start);

endmodule

`default_nettype wire

// ==== logic/cm_seq_counters.sv ====
// cm_seq_counters: byte counter inside a phase and operation counter across the run
`timescale 1ns/100ps
`default_nettype none

module cm_seq_counters (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  cm_pkg::ctrl_state_t   state,
    input  wire                         mem_ce,     // one count per memory access
    input  wire  cm_pkg::opcnt_t        no_op,      // operations in this run
    output cm_pkg::bcnt_t               byte_cnt,
    output logic                        rd_done,
    output logic                        wr_done,
    output logic                        next_op,
    output logic                        finish
);
    import cm_pkg::*;

    opcnt_t op_cnt;                                 // index of the current operation
    logic   last_op;

    assign rd_done = (state == RD_OPS) && (byte_cnt == bcnt_t'(OP_BYTES - 1));
    assign wr_done = (state == WR_RES) && (byte_cnt == bcnt_t'(RES_BYTES - 1));
    assign last_op = (op_cnt == no_op - opcnt_t'(1));   // no_op of zero is not supported
    assign next_op = wr_done & ~last_op;
    assign finish  = wr_done & last_op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            byte_cnt <= '0;
        else if (rd_done || wr_done)
            byte_cnt <= '0;                         // phase boundary
        else if (mem_ce)
            byte_cnt <= byte_cnt + bcnt_t'(1);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            op_cnt <= '0;
        else if (finish)
            op_cnt <= '0;                           // ready for the next run
        else if (next_op)
            op_cnt <= op_cnt + opcnt_t'(1);
    end

endmodule

`default_nettype wire

// ==== logic/cm_top.sv ====
// cm_top: memory-driven complex multiplier, register file, sequencer, memory port and core
`timescale 1ns/100ps
`default_nettype none

module cm_top #(
    parameter cm_pkg::addr_t RF_BADDR = '0      // register file base address
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  cm_pkg::addr_t   rf_addr,
    input  wire                   rf_wr,
    input  wire  cm_pkg::reg_t    rf_cfg,
    output cm_pkg::reg_t          rf_sts,
    output logic                  mem_ce,
    output logic                  mem_we,
    output cm_pkg::addr_t         mem_addr,
    output cm_pkg::byte_t         mem_wr_data,
    input  wire  cm_pkg::byte_t   mem_rd_data
);
    import cm_pkg::*;

    logic         start;
    opcnt_t       no_op;
    addr_t        op1_addr, op2_addr, res_addr;
    bcnt_t        byte_cnt;
    logic         rd_done, wr_done, next_op, finish;
    ctrl_state_t  state;
    logic         op_val, op_rdy, res_val, res_rdy;
    byte_t [3:0]  op_data;
    res_t         xr, yr;

    cm_regfile #(
        .RF_BADDR (RF_BADDR)
    ) i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rf_addr  (rf_addr),
        .rf_wr    (rf_wr),
        .rf_cfg   (rf_cfg),
        .rf_sts   (rf_sts),
        .start    (start),
        .no_op    (no_op),
        .op1_addr (op1_addr),
        .op2_addr (op2_addr),
        .res_addr (res_addr),
        .rd_done  (rd_done),
        .wr_done  (wr_done),
        .finish   (finish)
    );

    cm_ctrl_fsm i_ctrl_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .rd_done (rd_done),
        .res_val (res_val),
        .next_op (next_op),
        .finish  (finish),
        .state   (state)
    );

    cm_seq_counters i_seq_counters (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .mem_ce   (mem_ce),
        .no_op    (no_op),
        .byte_cnt (byte_cnt),
        .rd_done  (rd_done),
        .wr_done  (wr_done),
        .next_op  (next_op),
        .finish   (finish)
    );

    cm_mem_port i_mem_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .start       (start),
        .byte_cnt    (byte_cnt),
        .rd_done     (rd_done),
        .wr_done     (wr_done),
        .next_op     (next_op),
        .res_val     (res_val),
        .op1_addr    (op1_addr),
        .op2_addr    (op2_addr),
        .res_addr    (res_addr),
        .xr          (xr),
        .yr          (yr),
        .op_rdy      (op_rdy),
        .op_val      (op_val),
        .op_data     (op_data),
        .res_rdy     (res_rdy),
        .mem_ce      (mem_ce),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_data (mem_rd_data)
    );

    cm_mult_core i_mult_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .op_val  (op_val),
        .op_rdy  (op_rdy),
        .op_data (op_data),
        .res_val (res_val),
        .res_rdy (res_rdy),
        .xr      (xr),
        .yr      (yr)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
// tb_clk_gen: testbench clock and active-low reset generation
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,             // clock period
    parameter int RST_CYCLES = 16               // cycles with rst_n low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // free-running, stopped by $finish
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;                                     // release just after the edge
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_mem_model.sv ====
// byte-wide memory with one-cycle read latency and backdoor poke/peek
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model #(
    parameter int DEPTH = 1024                  // bytes, address wraps above this
) (
    input  wire                   clk,
    input  wire                   ce,           // access strobe
    input  wire                   we,           // write when set with ce
    input  wire  cm_pkg::addr_t   addr,
    input  wire  cm_pkg::byte_t   wr_data,
    output cm_pkg::byte_t         rd_data       // valid the cycle after a read
);
    import cm_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    byte_t mem [DEPTH];

    initial rd_data = '0;                       // bus idles at zero before the first read

    always @(posedge clk) begin
        if (ce && we)
            mem[addr[IDX_W-1:0]] = wr_data;     // write lands on this edge
        else if (ce)
            rd_data <= mem[addr[IDX_W-1:0]];    // held until the next read
    end

    // backdoor, used only while the DUT is idle
    task automatic poke(input addr_t a, input byte_t d);
        mem[a[IDX_W-1:0]] = d;
    endtask

    function automatic byte_t peek(input addr_t a);
        peek = mem[a[IDX_W-1:0]];
    endfunction

endmodule

`default_nettype wire

// ==== tests/tb_top.sv ====
// tb_top: table-driven runs of cm_top against a memory model and a reference complex product
`timescale 1ns/100ps
`default_nettype none

module tb_top;
    import cm_pkg::*;

    localparam addr_t        RF_BASE   = 32'h0000_0040;  // register file base under test
    localparam int           MEM_DEPTH = 1024;
    localparam int           NROWS     = 6;
    localparam int           DRV       = 1;              // ns after the rising edge
    localparam int           DONE_TMO  = 2000;           // cycles allowed for one run
    localparam int           IDLE_WAIT = 200;            // cycles watched after stray writes
    localparam logic [31:0]  SEED      = 32'ha133d63a;

    typedef struct packed {
        addr_t   op1;                                    // operand 1 base
        addr_t   op2;                                    // operand 2 base
        addr_t   res;                                    // result base
        opcnt_t  nop;                                    // operations in the run
        logic    rnd;                                    // operands from $urandom
        logic    stray;                                  // out-of-range writes only
        byte_t   x1, y1, x2, y2;                         // fixed operands of a single op
    } row_t;

    logic   clk, rst_n;
    addr_t  rf_addr;
    logic   rf_wr;
    reg_t   rf_cfg, rf_sts;
    logic   mem_ce, mem_we;
    addr_t  mem_addr;
    byte_t  mem_wr_data, mem_rd_data;

    row_t   rows [NROWS];
    string  names [NROWS];
    byte_t  exp_mem [MEM_DEPTH];                         // expected memory image
    int     errors, tests_run, tests_bad;
    logic   abort;                                       // stop after a hung run

    tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(16)) clk_i (.clk(clk), .rst_n(rst_n));

    tb_mem_model #(.DEPTH(MEM_DEPTH)) mem_i (
        .clk(clk), .ce(mem_ce), .we(mem_we), .addr(mem_addr),
        .wr_data(mem_wr_data), .rd_data(mem_rd_data)
    );

    cm_top #(.RF_BADDR(RF_BASE)) dut_i (
        .clk(clk), .rst_n(rst_n), .rf_addr(rf_addr), .rf_wr(rf_wr), .rf_cfg(rf_cfg),
        .rf_sts(rf_sts), .mem_ce(mem_ce), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wr_data(mem_wr_data), .mem_rd_data(mem_rd_data)
    );

    function automatic int sext8(input byte_t b);
        sext8 = int'($signed(b));
    endfunction

    // six result bytes, yr low then xr, each sign-extended to 24 bits
    function automatic logic [47:0] cmul_bytes(input byte_t x1, input byte_t y1,
                                               input byte_t x2, input byte_t y2);
        int xr_i;
        int yr_i;
        xr_i = sext8(x1) * sext8(x2) - sext8(y1) * sext8(y2);
        yr_i = sext8(x1) * sext8(y2) + sext8(y1) * sext8(x2);
        cmul_bytes = {xr_i[23:0], yr_i[23:0]};
    endfunction

    function automatic byte_t fill_byte(input int a);
        fill_byte = byte_t'(a) ^ byte_t'((a >> 8) * 29) ^ 8'h5a;    // all index bits matter
    endfunction

    task automatic set_byte(input int a, input byte_t d);
        exp_mem[a] = d;
        mem_i.poke(addr_t'(a), d);
    endtask

    task automatic reg_write(input addr_t a, input reg_t d);
        @(posedge clk);
        #DRV;
        rf_addr = a;
        rf_cfg  = d;
        rf_wr   = 1'b1;
        @(posedge clk);
        #DRV;
        rf_wr   = 1'b0;                                  // write taken on that edge
    endtask

    task automatic check_sts(input reg_t exp, inout int err);
        if (rf_sts !== exp) begin
            $display("ERR rf_sts got %08h exp %08h", rf_sts, exp);
            err++;
        end
    endtask

    task automatic check_mem(inout int err);
        byte_t got;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            got = mem_i.peek(addr_t'(a));
            if (got !== exp_mem[a]) begin
                $display("ERR mem[%03h] got %02h exp %02h", a, got, exp_mem[a]);
                err++;
            end
        end
    endtask

    task automatic run_row(input int t, inout int err);
        row_t         r;
        byte_t        ops [4];                           // x1 y1 x2 y2
        logic [47:0]  prod;
        int           n;
        r = rows[t];
        for (int i = 0; i < int'(r.nop); i++) begin
            if (r.rnd) begin
                for (int k = 0; k < 4; k++)
                    ops[k] = byte_t'($urandom);
            end else begin
                ops[0] = r.x1;
                ops[1] = r.y1;
                ops[2] = r.x2;
                ops[3] = r.y2;
            end
            set_byte(int'(r.op1) + 2*i, ops[0]);
            set_byte(int'(r.op1) + 2*i + 1, ops[1]);
            set_byte(int'(r.op2) + 2*i, ops[2]);
            set_byte(int'(r.op2) + 2*i + 1, ops[3]);
            prod = cmul_bytes(ops[0], ops[1], ops[2], ops[3]);
            for (int k = 0; k < 6; k++)
                exp_mem[int'(r.res) + 6*i + k] = prod[8*k +: 8];  // slot i of the result area
        end
        reg_write(RF_BASE + OFF_OP1, reg_t'(r.op1));
        reg_write(RF_BASE + OFF_OP2, reg_t'(r.op2));
        reg_write(RF_BASE + OFF_RES, reg_t'(r.res));
        reg_write(RF_BASE + OFF_NOP, reg_t'(r.nop));
        reg_write(RF_BASE + OFF_START, reg_t'(1));
        n = 0;
        while (!rf_sts[0] && n < DONE_TMO) begin
            @(posedge clk);
            #DRV;
            n++;
        end
        if (!rf_sts[0]) begin
            $display("test %0d timed out after %0d cycles waiting for the done bit", t, DONE_TMO);
            err++;
            abort = 1'b1;
            return;
        end
        check_sts(reg_t'(1), err);
        reg_write(RF_BASE + OFF_STS, '0);                // acknowledge done
        check_sts('0, err);
        check_mem(err);
    endtask

    task automatic run_stray(input int t, inout int err);
        reg_write(RF_BASE - addr_t'(1), reg_t'(1));
        reg_write(RF_BASE + addr_t'(6), reg_t'(1));
        reg_write(RF_BASE + OFF_START + addr_t'(32'h0000_0100), reg_t'(1));  // high bit aliases
        reg_write(RF_BASE + OFF_START + addr_t'(32'h8000_0000), reg_t'(1));
        for (int n = 0; n < IDLE_WAIT; n++) begin
            @(posedge clk);
            #DRV;
            if (rf_sts[0] || mem_ce) begin
                $display("test %0d: a run started after out-of-range register writes", t);
                err++;
                break;
            end
        end
        check_sts('0, err);
        check_mem(err);
    endtask

    initial begin
        int test_err;
        int w;
        rf_addr   = '0;
        rf_wr     = 1'b0;
        rf_cfg    = '0;
        errors    = 0;
        tests_run = 0;
        tests_bad = 0;
        abort     = 1'b0;
        void'($urandom(SEED));
        rows[0]  = '{32'h100, 32'h180, 32'h200, 32'd1, 1'b0, 1'b0, 8'h03, 8'h05, 8'h07, 8'h02};
        rows[1]  = '{32'h104, 32'h184, 32'h210, 32'd1, 1'b0, 1'b0, 8'h80, 8'h80, 8'h7f, 8'h80};
        rows[2]  = '{32'h108, 32'h188, 32'h220, 32'd1, 1'b0, 1'b0, 8'h80, 8'h7f, 8'h80, 8'h7f};
        rows[3]  = '{32'h110, 32'h190, 32'h240, 32'd8, 1'b1, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00};
        rows[4]  = '{32'h300, 32'h340, 32'h380, 32'd3, 1'b1, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00};
        rows[5]  = '{32'h000, 32'h000, 32'h000, 32'd0, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00, 8'h00};
        names[0] = "small_pos";
        names[1] = "neg_xr";
        names[2] = "neg_yr";
        names[3] = "random_8";
        names[4] = "new_bases";
        names[5] = "stray_wr";
        for (int a = 0; a < MEM_DEPTH; a++)
            set_byte(a, fill_byte(a));
        w = 0;
        while (rst_n !== 1'b1 && w < 40) begin
            @(posedge clk);
            w++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
            abort = 1'b1;
        end
        for (int t = 0; t < NROWS && !abort; t++) begin
            test_err = 0;
            if (rows[t].stray)
                run_stray(t, test_err);
            else
                run_row(t, test_err);
            $display("test %0d %s: %s, %0d errors", t, names[t],
                     (test_err == 0) ? "ok" : "BAD", test_err);
            tests_run++;
            errors += test_err;
            if (test_err != 0)
                tests_bad++;
        end
        $display("tests run %0d, tests bad %0d, errors %0d", tests_run, tests_bad, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
